// ==== Bender.yml ====
package:
  name: mlkem_compress

sources:
  - src/compress_pkg.sv
  - src/coef_mem.sv
  - src/compress_ctrl.sv
  - src/compress_round.sv
  - src/compress_pack_buf.sv
  - src/compress_top.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/compress_tb.sv

// ==== bench/compress_tb.sv ====
// Compression subsystem testbench, table-driven runs checked against a packing model
`timescale 1ns/1ps
`default_nettype none

module compress_tb;

    import compress_pkg::*;

    localparam int NUM_ROWS = 11;

    // One table row, one compression run
    typedef struct packed {
        compress_mode_t        mode;
        logic [2:0]            num_poly;
        logic [MEM_ADDR_W-1:0] base;
        logic                  edge_src;
        logic                  zero_mid;
    } row_t;

    logic                  clk;
    logic                  reset_n;
    logic                  zeroize;
    logic                  cmp_enable;
    compress_mode_t        mode;
    logic [2:0]            num_poly;
    logic [MEM_ADDR_W-1:0] src_base_addr;
    logic                  mem_wr_en;
    logic [MEM_ADDR_W-1:0] mem_wr_addr;
    logic [MEM_DATA_W-1:0] mem_wr_data;
    logic                  out_valid;
    logic [31:0]           out_data;
    logic                  done;

    row_t        rows [NUM_ROWS];
    logic [31:0] exp_q [$];
    logic [31:0] lfsr = 32'h48a8_208d;
    int          edge_vals [7] = '{0, 1, 832, 1664, 1665, 2496, 3328};
    // Bit stream model, LSB first
    logic [63:0] stream_acc;
    int          stream_bits;
    int          words;
    int          cycles;
    int          timeout_limit;
    bit          running;

    tb_clkgen #(.PERIOD_NS(20), .RESET_CYCLES(10)) clkgen0 (.clk(clk), .reset_n(reset_n));

    compress_top #(
        .ADDR_W (MEM_ADDR_W)
    ) dut0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .cmp_enable    (cmp_enable),
        .mode          (mode),
        .num_poly      (num_poly),
        .src_base_addr (src_base_addr),
        .mem_wr_en     (mem_wr_en),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .done          (done)
    );

    task abort_run();
        $display("Test FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task check_word(input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("Mismatch at time %0t: out_data expected %h got %h", $time, exp, got);
            abort_run();
        end
    endtask

    task check_done(input logic exp, input logic got);
        if (got !== exp) begin
            $display("Mismatch at time %0t: done expected %b got %b", $time, exp, got);
            abort_run();
        end
    endtask

    task check_count(input string name, input int exp, input int got);
        if (got != exp) begin
            $display("Mismatch at time %0t: %s expected %0d got %0d", $time, name, exp, got);
            abort_run();
        end
    endtask

    // Bits per field for each mode
    function automatic int d_of(input compress_mode_t m);
        case (m)
            compress1:  return 1;
            compress5:  return 5;
            compress11: return 11;
            default:    return 12;
        endcase
    endfunction

    // round(x * 2^d / q) mod 2^d, d = 12 keeps x as it is
    function automatic int compress_ref(input int x, input int d);
        if (d == 12) begin
            return x;
        end
        return ((2 * x * (1 << d) + MLKEM_Q) / (2 * MLKEM_Q)) % (1 << d);
    endfunction

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task next_coef(input int idx, input logic edge_src, output logic [COEF_W-1:0] c);
        int v;
        if (edge_src) begin
            c = COEF_W'(edge_vals[idx % 7]);
        end else begin
            v = 0;
            // One step per bit taken
            for (int b = 0; b < COEF_W; b++) begin
                lfsr = lfsr_step(lfsr);
                v = (v << 1) | int'(lfsr[0]);
            end
            c = COEF_W'(v % MLKEM_Q);
        end
    endtask

    // Append d bits above the stream, emit every full 32-bit word
    task append_field(input int val, input int d);
        stream_acc  = stream_acc | (64'(val) << stream_bits);
        stream_bits = stream_bits + d;
        if (stream_bits >= 32) begin
            exp_q.push_back(stream_acc[31:0]);
            stream_acc  = stream_acc >> 32;
            stream_bits = stream_bits - 32;
        end
    endtask

    task set_row(input int k, input compress_mode_t m, input int np, input int base,
                 input logic edge_src, input logic zero_mid);
        rows[k].mode     = m;
        rows[k].num_poly = 3'(np);
        rows[k].base     = MEM_ADDR_W'(base);
        rows[k].edge_src = edge_src;
        rows[k].zero_mid = zero_mid;
    endtask

    // Mode, polynomials, base, edge source, zeroize partway
    task load_table();
        set_row(0, compress1, 1, 'h00, 1'b0, 1'b0);
        set_row(1, compress5, 1, 'h00, 1'b0, 1'b0);
        set_row(2, compress11, 1, 'h00, 1'b0, 1'b0);
        set_row(3, compress12, 1, 'h00, 1'b0, 1'b0);
        set_row(4, compress1, 1, 'h00, 1'b1, 1'b0);
        set_row(5, compress5, 1, 'h00, 1'b1, 1'b0);
        set_row(6, compress11, 4, 'h40, 1'b0, 1'b1);
        set_row(7, compress5, 4, 'h9c, 1'b0, 1'b0);
        set_row(8, compress12, 4, 'h40, 1'b1, 1'b0);
        set_row(9, compress11, 4, 'h13, 1'b0, 1'b0);
        set_row(10, compress1, 4, 'hf0, 1'b1, 1'b0);
    endtask

    // Output monitor, sampled away from the rising edge
    always @(negedge clk) begin
        if (reset_n && out_valid) begin
            if (done) begin
                $display("out_valid high while done is high at time %0t", $time);
                abort_run();
            end
            if (exp_q.size() == 0) begin
                $display("Output word at time %0t with no word left to expect", $time);
                abort_run();
            end
            check_word(exp_q.pop_front(), out_data);
            words = words + 1;
        end
    end

    // Watchdog counts only cycles spent in a run
    always @(posedge clk) begin
        if (running) begin
            cycles = cycles + 1;
            if (cycles > timeout_limit) begin
                $display("Timeout, run did not finish within %0d cycles", timeout_limit);
                abort_run();
            end
        end
    end

    initial begin
        row_t                  r;
        int                    d;
        logic [MEM_DATA_W-1:0] w;
        logic [COEF_W-1:0]     c;
        zeroize       = 1'b0;
        cmp_enable    = 1'b0;
        mode          = compress1;
        num_poly      = '0;
        src_base_addr = '0;
        mem_wr_en     = 1'b0;
        mem_wr_addr   = '0;
        mem_wr_data   = '0;
        running       = 1'b0;
        cycles        = 0;
        words         = 0;
        load_table();
        timeout_limit = 0;
        for (int k = 0; k < NUM_ROWS; k++) begin
            timeout_limit += int'(rows[k].num_poly) * 64 * 2 + 50;
        end

        @(posedge reset_n);
        @(negedge clk);
        check_done(1'b1, done);

        for (int k = 0; k < NUM_ROWS; k++) begin
            r = rows[k];
            d = d_of(r.mode);
            exp_q.delete();
            stream_acc  = '0;
            stream_bits = 0;
            words       = 0;

            // Load the polynomials and build the expected stream
            for (int i = 0; i < int'(r.num_poly) * 64; i++) begin
                for (int j = 0; j < COEF_PER_WORD; j++) begin
                    next_coef(i * COEF_PER_WORD + j, r.edge_src, c);
                    w[j*COEF_W +: COEF_W] = c;
                    append_field(compress_ref(int'(c), d), d);
                end
                @(posedge clk);
                mem_wr_en     <= 1'b1;
                mem_wr_addr   <= r.base + MEM_ADDR_W'(i);
                mem_wr_data   <= w;
                mode          <= r.mode;
                num_poly      <= r.num_poly;
                src_base_addr <= r.base;
            end
            @(posedge clk);
            mem_wr_en <= 1'b0;
            @(negedge clk);
            check_done(1'b1, done);

            // Start pulse, done drops on the following edge
            running = 1'b1;
            @(posedge clk);
            cmp_enable <= 1'b1;
            @(posedge clk);
            cmp_enable <= 1'b0;
            @(negedge clk);
            check_done(1'b0, done);

            if (r.zero_mid) begin
                repeat (30) @(posedge clk);
                zeroize <= 1'b1;
                @(posedge clk);
                zeroize <= 1'b0;
                @(negedge clk);
                check_done(1'b1, done);
                exp_q.delete();
                // Monitor flags any word that still leaves
                repeat (20) begin
                    @(negedge clk);
                    check_done(1'b1, done);
                end
            end else begin
                while (!done) begin
                    @(negedge clk);
                end
                check_count("word count", int'(r.num_poly) * 8 * d, words);
                check_count("words still expected", 0, exp_q.size());
            end
            running = 1'b0;
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clkgen.sv ====
// Testbench clock and reset generator, free-running clock with a held reset
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset_n
);

    initial clk = 1'b0;
    always #(PERIOD_NS / 2) clk = ~clk;

    // Reset low from time zero, released on a rising edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/compress_pkg.sv
src/coef_mem.sv
src/compress_ctrl.sv
src/compress_round.sv
src/compress_pack_buf.sv
src/compress_top.sv
bench/tb_clkgen.sv
bench/compress_tb.sv

// ==== src/coef_mem.sv ====
// Coefficient memory, synchronous write and registered read
`timescale 1ns/1ps
`default_nettype none

module coef_mem #(
    parameter int ADDR_W = compress_pkg::MEM_ADDR_W
) (
    input  wire                                 clk,

    // Write port, loaded from outside while idle
    input  wire                                 wr_en,
    input  wire  [ADDR_W-1:0]                   wr_addr,
    input  wire  [compress_pkg::MEM_DATA_W-1:0] wr_data,

    // Read port, driven by the read controller
    input  wire                                 rd_en,
    input  wire  [ADDR_W-1:0]                   rd_addr,
    output logic [compress_pkg::MEM_DATA_W-1:0] rd_data
);

    import compress_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    // Four packed coefficients per word
    logic [MEM_DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle of read latency, data held between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/compress_ctrl.sv ====
// Compression read controller, walks the polynomials at a per-mode pace
`timescale 1ns/1ps
`default_nettype none

module compress_ctrl #(
    parameter int ADDR_W = compress_pkg::MEM_ADDR_W
) (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           zeroize,

    input  wire                           cmp_enable,
    input  wire compress_pkg::compress_mode_t mode,
    input  wire  [2:0]                    num_poly,
    input  wire  [ADDR_W-1:0]             src_base_addr,

    output logic                          rd_en,
    output logic [ADDR_W-1:0]             rd_addr,
    output logic                          data_valid,
    output compress_pkg::compress_mode_t  mode_q,
    output logic                          ctrl_idle
);

    import compress_pkg::*;

    localparam int WORDS_PER_POLY = MLKEM_N / COEF_PER_WORD;

    cmp_read_state_e state_ps;
    cmp_read_state_e state_ns;
    logic [11:0]     pace;
    logic [11:0]     pace_init;
    logic [ADDR_W-1:0] last_addr;
    logic            arc_idle_mem;
    logic            arc_mem_idle;
    logic            ld_addr;
    rw_e             rd_kind;

    // Pacer patterns keep the packing buffer at or below 96 bits
    // 8 reads in 12 cycles for the wide modes
    always_comb begin
        unique case (mode)
            compress1:  pace_init = '1;
            compress5:  pace_init = '1;
            compress11: pace_init = 12'b0011_0111_0111;
            compress12: pace_init = 12'b0110_1101_1011;
            default:    pace_init = '0;
        endcase
    end

    // Last word of the last polynomial
    assign last_addr = src_base_addr + ADDR_W'(num_poly * WORDS_PER_POLY - 1);

    // FSM arcs
    assign arc_idle_mem = (state_ps == CMP_RD_IDLE) & cmp_enable;
    assign arc_mem_idle = (state_ps == CMP_RD_MEM) & pace[0] & (rd_addr == last_addr);
    // Reload at start, and again on the way back to idle
    assign ld_addr      = arc_idle_mem | arc_mem_idle;

    always_comb begin
        unique case (state_ps)
            CMP_RD_IDLE: state_ns = arc_idle_mem ? CMP_RD_MEM : CMP_RD_IDLE;
            CMP_RD_MEM:  state_ns = arc_mem_idle ? CMP_RD_IDLE : CMP_RD_MEM;
            default:     state_ns = CMP_RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_ps <= CMP_RD_IDLE;
        end else if (zeroize) begin
            state_ps <= CMP_RD_IDLE;
        end else begin
            state_ps <= state_ns;
        end
    end

    // Pacer rotates every cycle spent reading
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pace <= '0;
        end else if (zeroize) begin
            pace <= '0;
        end else if (ld_addr) begin
            pace <= pace_init;
        end else if (state_ps == CMP_RD_MEM) begin
            pace <= {pace[0], pace[11:1]};
        end
    end

    // Address counter, steps on each paced read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr <= '0;
        end else if (zeroize) begin
            rd_addr <= '0;
        end else if (ld_addr) begin
            rd_addr <= src_base_addr;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // Mode held for the whole run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_q <= compress1;
        end else if (zeroize) begin
            mode_q <= compress1;
        end else if (arc_idle_mem) begin
            mode_q <= mode;
        end
    end

    // Read request
    assign rd_kind   = ((state_ps == CMP_RD_MEM) & pace[0]) ? RW_READ : RW_IDLE;
    assign rd_en     = (rd_kind == RW_READ);
    assign ctrl_idle = (state_ps == CMP_RD_IDLE);

    // Valid lines up with the memory read latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_valid <= 1'b0;
        end else if (zeroize) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= rd_en;
        end
    end

    // Run bounds are taken live from the inputs and must hold during a run
    assert property (@(posedge clk) disable iff (!reset_n)
        !ctrl_idle |-> ($stable(num_poly) && $stable(src_base_addr)));

endmodule

`default_nettype wire

// ==== src/compress_pack_buf.sv ====
// Packing buffer, joins d-bit fields into 32-bit little-endian words
`timescale 1ns/1ps
`default_nettype none

module compress_pack_buf (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize,

    input  wire                                 fields_valid,
    input  wire  [compress_pkg::MEM_DATA_W-1:0] fields,
    input  wire compress_pkg::compress_mode_t   mode_r,
    input  wire                                 ctrl_idle,

    output logic                                out_valid,
    output logic [31:0]                         out_data,
    output logic                                done
);

    import compress_pkg::*;

    localparam int BUF_W  = 96;
    localparam int FILL_W = 7;

    logic [BUF_W-1:0]      acc;
    logic [BUF_W-1:0]      acc_shift;
    logic [BUF_W-1:0]      acc_nxt;
    logic [FILL_W-1:0]     fill;
    logic [FILL_W-1:0]     fill_shift;
    logic [FILL_W-1:0]     fill_nxt;
    logic [MEM_DATA_W-1:0] packed_bits;
    logic [3:0]            d;
    logic                  idle_q;

    assign d = mode_bits(mode_r);

    // Squeeze the four 12-bit lanes down to 4*d contiguous bits
    always_comb begin
        packed_bits = '0;
        for (int i = 0; i < COEF_PER_WORD; i++) begin
            packed_bits |= MEM_DATA_W'(fields[i*COEF_W +: COEF_W]) << (i * d);
        end
    end

    // Word leaves from the bottom while new bits land above the fill
    always_comb begin
        acc_shift  = out_valid ? (acc >> 32) : acc;
        fill_shift = out_valid ? (fill - FILL_W'(32)) : fill;
        acc_nxt    = acc_shift;
        fill_nxt   = fill_shift;
        if (fields_valid) begin
            acc_nxt  = acc_shift | (BUF_W'(packed_bits) << fill_shift);
            fill_nxt = fill_shift + FILL_W'(COEF_PER_WORD * d);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc  <= '0;
            fill <= '0;
        end else if (zeroize) begin
            acc  <= '0;
            fill <= '0;
        end else begin
            acc  <= acc_nxt;
            fill <= fill_nxt;
        end
    end

    assign out_valid = (fill >= FILL_W'(32));
    assign out_data  = acc[31:0];

    // Delayed idle covers the word still in the memory stage
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idle_q <= 1'b1;
        end else if (zeroize) begin
            idle_q <= 1'b1;
        end else begin
            idle_q <= ctrl_idle;
        end
    end

    assign done = ctrl_idle & idle_q & ~fields_valid & (fill == '0);

    // Read pacing keeps the buffer from overflowing
    assert property (@(posedge clk) disable iff (!reset_n)
        fill <= FILL_W'(BUF_W));

endmodule

`default_nettype wire

// ==== src/compress_pkg.sv ====
// ML-KEM compression constants, mode and state encodings, shared helper
`default_nettype none

package compress_pkg;

    // ML-KEM ring parameters
    localparam int MLKEM_Q = 3329;
    localparam int MLKEM_N = 256;

    // Coefficient and memory word layout
    localparam int COEF_W        = 12;
    localparam int COEF_PER_WORD = 4;
    localparam int MEM_DATA_W    = COEF_W * COEF_PER_WORD;
    // 4 polynomials x 64 words
    localparam int MEM_ADDR_W    = 8;

    // Compression mode, selects d
    typedef enum logic [1:0] {
        compress1  = 2'b00,
        compress5  = 2'b01,
        compress11 = 2'b10,
        compress12 = 2'b11
    } compress_mode_t;

    // Read FSM states
    typedef enum logic {
        CMP_RD_IDLE = 1'b0,
        CMP_RD_MEM  = 1'b1
    } cmp_read_state_e;

    // Memory request kind
    typedef enum logic {
        RW_IDLE = 1'b0,
        RW_READ = 1'b1
    } rw_e;

    // Output bits per coefficient for each mode
    function automatic logic [3:0] mode_bits(input compress_mode_t m);
        unique case (m)
            compress1:  mode_bits = 4'd1;
            compress5:  mode_bits = 4'd5;
            compress11: mode_bits = 4'd11;
            compress12: mode_bits = 4'd12;
            default:    mode_bits = 4'd12;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/compress_round.sv ====
// Four-lane rounding stage, compresses coefficients to d bits
`timescale 1ns/1ps
`default_nettype none

module compress_round (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize,

    input  wire                                 data_valid,
    input  wire compress_pkg::compress_mode_t   mode_q,
    input  wire  [compress_pkg::MEM_DATA_W-1:0] rd_data,

    output logic                                fields_valid,
    output logic [compress_pkg::MEM_DATA_W-1:0] fields,
    output compress_pkg::compress_mode_t        mode_r
);

    import compress_pkg::*;

    // floor(2^24 / q), one correction step covers the error
    localparam int RECIP       = 5039;
    localparam int RECIP_SHIFT = 24;

    logic [MEM_DATA_W-1:0] fields_nxt;
    logic [3:0]            d;

    // round(x * 2^d / q) mod 2^d
    function automatic logic [COEF_W-1:0] round_coef(input logic [COEF_W-1:0] x,
                                                     input logic [3:0] dd);
        logic [22:0] num;
        logic [35:0] prod;
        logic [11:0] qt;
        logic [23:0] rem;
        // Add q/2 for rounding, q is odd so no ties
        num  = (23'(x) << dd) + 23'(MLKEM_Q / 2);
        prod = 36'(num) * 36'(RECIP);
        qt   = prod[RECIP_SHIFT +: 12];
        rem  = 24'(num) - 24'(qt) * 24'(MLKEM_Q);
        // Estimate is low by at most one
        if (rem >= 24'(MLKEM_Q)) begin
            qt = qt + 12'd1;
        end
        round_coef = qt & ((12'd1 << dd) - 12'd1);
    endfunction

    function automatic logic coefs_below_q(input logic [MEM_DATA_W-1:0] w);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < COEF_PER_WORD; i++) begin
            ok &= (w[i*COEF_W +: COEF_W] < COEF_W'(MLKEM_Q));
        end
        return ok;
    endfunction

    assign d = mode_bits(mode_q);

    // d = 12 is plain byte encoding
    always_comb begin
        logic [COEF_W-1:0] x;
        for (int i = 0; i < COEF_PER_WORD; i++) begin
            x = rd_data[i*COEF_W +: COEF_W];
            fields_nxt[i*COEF_W +: COEF_W] = (mode_q == compress12) ? x : round_coef(x, d);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fields_valid <= 1'b0;
            fields       <= '0;
            mode_r       <= compress1;
        end else if (zeroize) begin
            fields_valid <= 1'b0;
            fields       <= '0;
            mode_r       <= compress1;
        end else begin
            fields_valid <= data_valid;
            mode_r       <= mode_q;
            if (data_valid) begin
                fields <= fields_nxt;
            end
        end
    end

    // Memory contents must be reduced mod q
    assert property (@(posedge clk) disable iff (!reset_n)
        data_valid |-> coefs_below_q(rd_data));

endmodule

`default_nettype wire

// ==== src/compress_top.sv ====
// ML-KEM compression subsystem, memory plus read, round and pack stages
`timescale 1ns/1ps
`default_nettype none

module compress_top #(
    parameter int ADDR_W = compress_pkg::MEM_ADDR_W
) (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize,

    input  wire                                 cmp_enable,
    input  wire compress_pkg::compress_mode_t   mode,
    input  wire  [2:0]                          num_poly,
    input  wire  [ADDR_W-1:0]                   src_base_addr,

    // Memory load port
    input  wire                                 mem_wr_en,
    input  wire  [ADDR_W-1:0]                   mem_wr_addr,
    input  wire  [compress_pkg::MEM_DATA_W-1:0] mem_wr_data,

    output logic                                out_valid,
    output logic [31:0]                         out_data,
    output logic                                done
);

    import compress_pkg::*;

    // Read stage to memory
    logic                  rd_en;
    logic [ADDR_W-1:0]     rd_addr;
    logic [MEM_DATA_W-1:0] rd_data;
    logic                  ctrl_idle;

    // Memory stage to round stage
    logic                  data_valid;
    compress_mode_t        mode_q;

    // Round stage to pack stage
    logic                  fields_valid;
    logic [MEM_DATA_W-1:0] fields;
    compress_mode_t        mode_r;

    coef_mem #(
        .ADDR_W (ADDR_W)
    ) coef_mem0 (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    compress_ctrl #(
        .ADDR_W (ADDR_W)
    ) compress_ctrl0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .cmp_enable    (cmp_enable),
        .mode          (mode),
        .num_poly      (num_poly),
        .src_base_addr (src_base_addr),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .data_valid    (data_valid),
        .mode_q        (mode_q),
        .ctrl_idle     (ctrl_idle)
    );

    compress_round compress_round0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .data_valid   (data_valid),
        .mode_q       (mode_q),
        .rd_data      (rd_data),
        .fields_valid (fields_valid),
        .fields       (fields),
        .mode_r       (mode_r)
    );

    compress_pack_buf compress_pack_buf0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .fields_valid (fields_valid),
        .fields       (fields),
        .mode_r       (mode_r),
        .ctrl_idle    (ctrl_idle),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .done         (done)
    );

endmodule

`default_nettype wire
